// File: src/apuPkg.sv
// Shared APU definitions: register addresses, lookup tables,
// frame step counts and the structs passed between blocks
`default_nettype none

package apuPkg;

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	localparam logic [4:0] AddrStatus = 5'h15;
	localparam logic [4:0] AddrFrame = 5'h17;

	// ----------------------------------------
	// Bus and clock bundles
	// ----------------------------------------
	typedef struct packed {
		logic [1:0] regIndex;
		logic [7:0] data;
	} RegWriteT;

	typedef struct packed {
		logic quarter;
		logic half;
		logic apuTick;
	} FrameClocksT;

	typedef struct packed {
		logic [3:0] pulse1;
		logic [3:0] pulse2;
		logic [3:0] noise;
	} ChannelLevelsT;

	// ----------------------------------------
	// Tables
	// ----------------------------------------
	typedef logic [7:0] LengthTableT [32];
	typedef logic [11:0] NoisePeriodTableT [16];

	// Length load values, already doubled
	localparam LengthTableT LengthTable = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	// Noise timer periods in CPU cycles
	localparam NoisePeriodTableT NoisePeriodTable = '{
		12'd4, 12'd8, 12'd16, 12'd32, 12'd64, 12'd96, 12'd128, 12'd160,
		12'd202, 12'd254, 12'd380, 12'd508, 12'd762, 12'd1016, 12'd2034, 12'd4068
	};

	// Frame sequencer step points, counted in CPU cycles
	localparam logic [16:0] StepQuarter1 = 17'd7456;
	localparam logic [16:0] StepHalf2 = 17'd14912;
	localparam logic [16:0] StepQuarter3 = 17'd22370;
	localparam logic [16:0] StepFrame4 = 17'd29828;
	localparam logic [16:0] StepWrap4 = 17'd29829;
	localparam logic [16:0] StepFrame5 = 17'd37280;
	localparam logic [16:0] StepWrap5 = 17'd37281;

endpackage

`default_nettype wire

// File: src/lengthCounter.sv
// Channel length counter with table load, half-frame countdown and halt
`timescale 1ns/1ps
`default_nettype none

module lengthCounter (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic load,
	input logic [4:0] loadIndex,
	input logic halfClock,
	input logic halt,
	input logic enabled,
	output logic nonZero
);

	logic [7:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (ce) begin
			if (!enabled) begin
				// Disabled channel is silenced right away
				count <= '0;
			end else if (load) begin
				count <= apuPkg::LengthTable[loadIndex];
			end else if (halfClock && !halt && count != 8'd0) begin
				count <= count - 8'd1;
			end
		end
	end

	assign nonZero = (count != 8'd0);

endmodule

`default_nettype wire

// File: src/envelope.sv
// Envelope generator: divider, decay level, loop and constant volume
`timescale 1ns/1ps
`default_nettype none

module envelope (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic quarterClock,
	input logic restart,
	input logic loopFlag,
	input logic constantVolume,
	input logic [3:0] volume,
	output logic [3:0] level
);

	logic startFlag;
	logic [3:0] divider;
	logic [3:0] decayLevel;

	always_ff @(posedge clk) begin
		if (reset) begin
			startFlag <= 1'b0;
			divider <= '0;
			decayLevel <= '0;
		end else if (ce) begin
			if (quarterClock) begin
				if (startFlag) begin
					startFlag <= 1'b0;
					decayLevel <= 4'd15;
					divider <= volume;
				end else if (divider == 4'd0) begin
					divider <= volume;
					if (decayLevel != 4'd0)
						decayLevel <= decayLevel - 4'd1;
					else if (loopFlag)
						decayLevel <= 4'd15;
				end else begin
					divider <= divider - 4'd1;
				end
			end
			// Request is held until the next quarter clock
			if (restart)
				startFlag <= 1'b1;
		end
	end

	assign level = constantVolume ? volume : decayLevel;

endmodule

`default_nettype wire

// File: src/pulseChannel.sv
// Pulse channel: registers, 11-bit timer, duty sequencer and output gate
`timescale 1ns/1ps
`default_nettype none

module pulseChannel #(
	parameter int ChannelIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic write,
	input apuPkg::RegWriteT regWord,
	input apuPkg::FrameClocksT clocks,
	input logic enabled,
	output logic [3:0] level,
	output logic nonZero
);

	logic [1:0] duty;
	logic haltLoop;
	logic constantFlag;
	logic [3:0] volume;
	logic [10:0] period;
	logic [10:0] timer;
	logic [2:0] step;
	logic lengthWrite;
	logic dutyHigh;
	logic periodValid;
	logic [3:0] envLevel;

	// Register 3 also reloads length and restarts the envelope
	assign lengthWrite = write && regWord.regIndex == 2'd3;

	// ----------------------------------------
	// Registers, timer and sequencer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			duty <= '0;
			haltLoop <= 1'b0;
			constantFlag <= 1'b0;
			volume <= '0;
			period <= '0;
			timer <= '0;
			step <= '0;
		end else if (ce) begin
			if (clocks.apuTick) begin
				if (timer == 11'd0) begin
					timer <= period;
					// Sequencer runs downward through the duty pattern
					step <= step - 3'd1;
				end else begin
					timer <= timer - 11'd1;
				end
			end

			if (write) begin
				case (regWord.regIndex)
					2'd0: begin
						duty <= regWord.data[7:6];
						haltLoop <= regWord.data[5];
						constantFlag <= regWord.data[4];
						volume <= regWord.data[3:0];
					end
					2'd2: period[7:0] <= regWord.data;
					2'd3: begin
						period[10:8] <= regWord.data[2:0];
						step <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	envelope i_envelope (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.quarterClock(clocks.quarter),
		.restart(lengthWrite),
		.loopFlag(haltLoop),
		.constantVolume(constantFlag),
		.volume(volume),
		.level(envLevel)
	);

	lengthCounter i_lengthCounter (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.load(lengthWrite),
		.loadIndex(regWord.data[7:3]),
		.halfClock(clocks.half),
		.halt(haltLoop),
		.enabled(enabled),
		.nonZero(nonZero)
	);

	// ----------------------------------------
	// Output
	// ----------------------------------------
	always_comb begin
		case (duty)
			2'd0: dutyHigh = (step == 3'd7);
			2'd1: dutyHigh = (step >= 3'd6);
			2'd2: dutyHigh = (step >= 3'd4);
			default: dutyHigh = (step < 3'd6);
		endcase
	end

	// Periods below 8 are ultrasonic and stay muted
	assign periodValid = |period[10:3];

	assign level = (nonZero && periodValid && dutyHigh) ? envLevel : 4'd0;

	// Every table entry is nonzero, so a length write on an enabled channel must start it
	assert property (@(posedge clk) disable iff (reset)
		(ce && lengthWrite && enabled) |=> nonZero)
		else $error("pulse %0d did not start after length write", ChannelIndex + 1);

endmodule

`default_nettype wire

// File: src/noiseChannel.sv
// Noise channel: registers, period lookup, timer and 15-bit feedback shifter
`timescale 1ns/1ps
`default_nettype none

module noiseChannel (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic write,
	input apuPkg::RegWriteT regWord,
	input apuPkg::FrameClocksT clocks,
	input logic enabled,
	output logic [3:0] level,
	output logic nonZero
);

	logic loopFlag;
	logic constantFlag;
	logic [3:0] volume;
	logic shortMode;
	logic [3:0] periodIndex;
	logic [11:0] timer;
	logic [14:0] shifter;
	logic feedback;
	logic lengthWrite;
	logic [3:0] envLevel;

	assign lengthWrite = write && regWord.regIndex == 2'd3;

	// Short mode taps bit 6 for a 93-step sequence
	assign feedback = shifter[0] ^ (shortMode ? shifter[6] : shifter[1]);

	always_ff @(posedge clk) begin
		if (reset) begin
			loopFlag <= 1'b0;
			constantFlag <= 1'b0;
			volume <= '0;
			shortMode <= 1'b0;
			periodIndex <= '0;
			timer <= '0;
			shifter <= 15'd1;
		end else if (ce) begin
			if (timer == 12'd0) begin
				timer <= apuPkg::NoisePeriodTable[periodIndex] - 12'd1;
				shifter <= {feedback, shifter[14:1]};
			end else begin
				timer <= timer - 12'd1;
			end

			if (write) begin
				case (regWord.regIndex)
					2'd0: begin
						loopFlag <= regWord.data[5];
						constantFlag <= regWord.data[4];
						volume <= regWord.data[3:0];
					end
					2'd2: begin
						shortMode <= regWord.data[7];
						periodIndex <= regWord.data[3:0];
					end
					default: ;
				endcase
			end
		end
	end

	envelope i_envelope (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.quarterClock(clocks.quarter),
		.restart(lengthWrite),
		.loopFlag(loopFlag),
		.constantVolume(constantFlag),
		.volume(volume),
		.level(envLevel)
	);

	lengthCounter i_lengthCounter (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.load(lengthWrite),
		.loadIndex(regWord.data[7:3]),
		.halfClock(clocks.half),
		.halt(loopFlag),
		.enabled(enabled),
		.nonZero(nonZero)
	);

	assign level = (!nonZero || shifter[0]) ? 4'd0 : envLevel;

endmodule

`default_nettype wire

// File: src/frameSequencer.sv
// Frame counter: half-rate tick, quarter and half frame clocks, frame interrupt
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic frameWrite,
	input logic [7:0] frameData,
	input logic statusRead,
	output apuPkg::FrameClocksT clocks,
	output logic frameFlag,
	output logic irq
);

	logic [16:0] stepCount;
	logic fiveStep;
	logic inhibit;
	logic tickPhase;
	logic pendingClock;
	logic quarterMatch;
	logic halfMatch;
	logic wrapPoint;

	// ----------------------------------------
	// Step decode
	// ----------------------------------------
	always_comb begin
		quarterMatch = 1'b0;
		halfMatch = 1'b0;
		if (stepCount == apuPkg::StepQuarter1 || stepCount == apuPkg::StepQuarter3)
			quarterMatch = 1'b1;
		if (stepCount == apuPkg::StepHalf2 ||
			stepCount == (fiveStep ? apuPkg::StepFrame5 : apuPkg::StepFrame4)) begin
			quarterMatch = 1'b1;
			halfMatch = 1'b1;
		end
		wrapPoint = stepCount == (fiveStep ? apuPkg::StepWrap5 : apuPkg::StepWrap4);
	end

	// Clocks are single-ce pulses; a 5-step write adds one of each
	always_comb begin
		clocks.quarter = ce && (quarterMatch || pendingClock);
		clocks.half = ce && (halfMatch || pendingClock);
		clocks.apuTick = ce && tickPhase;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stepCount <= '0;
			fiveStep <= 1'b0;
			inhibit <= 1'b0;
			tickPhase <= 1'b0;
			pendingClock <= 1'b0;
			frameFlag <= 1'b0;
		end else begin
			if (statusRead)
				frameFlag <= 1'b0;

			if (ce) begin
				tickPhase <= !tickPhase;
				pendingClock <= 1'b0;
				stepCount <= wrapPoint ? 17'd0 : stepCount + 17'd1;

				// A flag raised in the same cycle as a status read survives it
				if (!fiveStep && !inhibit && stepCount == apuPkg::StepFrame4)
					frameFlag <= 1'b1;

				if (frameWrite) begin
					fiveStep <= frameData[7];
					inhibit <= frameData[6];
					stepCount <= '0;
					pendingClock <= frameData[7];
					if (frameData[6])
						frameFlag <= 1'b0;
				end
			end
		end
	end

	assign irq = frameFlag && !inhibit;

endmodule

`default_nettype wire

// File: src/apuTop.sv
// APU top level: write decode, enable register, status byte, irq
// and the pulse, noise and frame sequencer instances
`timescale 1ns/1ps
`default_nettype none

module apuTop (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic regWrite,
	input logic regRead,
	input logic [4:0] regAddr,
	input logic [7:0] regData,
	output logic [7:0] statusData,
	output logic irq,
	output apuPkg::ChannelLevelsT levels
);

	apuPkg::RegWriteT regWord;
	apuPkg::FrameClocksT frameClocks;
	logic pulse1Write;
	logic pulse2Write;
	logic noiseWrite;
	logic controlWrite;
	logic frameWrite;
	logic statusRead;
	logic [3:0] enableBits;
	logic frameFlag;
	logic pulse1NonZero;
	logic pulse2NonZero;
	logic noiseNonZero;

	// ----------------------------------------
	// Write decode by register group
	// ----------------------------------------
	assign regWord.regIndex = regAddr[1:0];
	assign regWord.data = regData;

	assign pulse1Write = regWrite && regAddr[4:2] == 3'd0;
	assign pulse2Write = regWrite && regAddr[4:2] == 3'd1;
	assign noiseWrite = regWrite && regAddr[4:2] == 3'd3;
	assign controlWrite = regWrite && regAddr[4:2] == 3'd5;
	assign frameWrite = controlWrite && regAddr == apuPkg::AddrFrame;
	assign statusRead = regRead && regAddr == apuPkg::AddrStatus;

	// Bit 2 belongs to the triangle slot and is kept for register compatibility
	always_ff @(posedge clk) begin
		if (reset)
			enableBits <= '0;
		else if (ce && controlWrite && regAddr == apuPkg::AddrStatus)
			enableBits <= regData[3:0];
	end

	// ----------------------------------------
	// Blocks
	// ----------------------------------------
	frameSequencer i_frameSequencer (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.frameWrite(frameWrite),
		.frameData(regData),
		.statusRead(statusRead),
		.clocks(frameClocks),
		.frameFlag(frameFlag),
		.irq(irq)
	);

	pulseChannel #(.ChannelIndex(0)) i_pulse1 (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.write(pulse1Write),
		.regWord(regWord),
		.clocks(frameClocks),
		.enabled(enableBits[0]),
		.level(levels.pulse1),
		.nonZero(pulse1NonZero)
	);

	pulseChannel #(.ChannelIndex(1)) i_pulse2 (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.write(pulse2Write),
		.regWord(regWord),
		.clocks(frameClocks),
		.enabled(enableBits[1]),
		.level(levels.pulse2),
		.nonZero(pulse2NonZero)
	);

	noiseChannel i_noise (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.write(noiseWrite),
		.regWord(regWord),
		.clocks(frameClocks),
		.enabled(enableBits[3]),
		.level(levels.noise),
		.nonZero(noiseNonZero)
	);

	// Status byte layout: frame flag at bit 6, channel activity in the low nibble
	assign statusData = {1'b0, frameFlag, 2'b00, noiseNonZero, 1'b0,
		pulse2NonZero, pulse1NonZero};

	assert property (@(posedge clk) reset |-> !(pulse1Write || pulse2Write || noiseWrite))
		else $error("channel register write during reset");

endmodule

`default_nettype wire

// File: bench/apuBench.sv
// APU testbench: clock, reset, DUT, noise shift register model,
// value check and directed tests
`timescale 1ns/1ps
`default_nettype none

module apuBench;

	localparam int DriveDelay = 2;
	// Two 4-step frames plus under 10000 cycles for the other tests, with margin
	localparam int TimeoutCycles = 120000;
	localparam int NoisePeriod0 = 4;
	// Eight duty steps of (period 20 + 1) APU ticks, two CPU cycles per tick
	localparam int DutyWindow = 8 * (20 + 1) * 2;

	logic clk;
	logic reset;
	logic ce;
	logic regWrite;
	logic regRead;
	logic [4:0] regAddr;
	logic [7:0] regData;
	logic [7:0] statusData;
	logic irq;
	apuPkg::ChannelLevelsT levels;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	logic [14:0] noiseModel;
	int noiseTimer;
	logic shortModel;

	apuTop i_apuTop (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.regWrite(regWrite),
		.regRead(regRead),
		.regAddr(regAddr),
		.regData(regData),
		.statusData(statusData),
		.irq(irq),
		.levels(levels)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the tests did not complete within %0d cycles", TimeoutCycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// Noise reference: period index 0 from reset, mode taken from writes to 0Eh
	always @(posedge clk) begin
		if (reset) begin
			noiseModel = 15'd1;
			noiseTimer = 0;
			shortModel = 1'b0;
		end else begin
			if (noiseTimer == 0) begin
				noiseTimer = NoisePeriod0 - 1;
				noiseModel = {noiseModel[0] ^ (shortModel ? noiseModel[6] : noiseModel[1]),
					noiseModel[14:1]};
			end else begin
				noiseTimer = noiseTimer - 1;
			end
			if (regWrite && regAddr == 5'h0E)
				shortModel = regData[7];
		end
	end

	// ----------------------------------------
	// Bus and check helpers
	// ----------------------------------------
	task automatic waitCycle();
		@(posedge clk);
		#DriveDelay;
	endtask

	task automatic writeReg(input logic [4:0] addr, input logic [7:0] data);
		waitCycle();
		regWrite = 1'b1;
		regAddr = addr;
		regData = data;
		waitCycle();
		regWrite = 1'b0;
	endtask

	task automatic readStatus(output logic [7:0] status);
		waitCycle();
		regRead = 1'b1;
		regAddr = apuPkg::AddrStatus;
		status = statusData;
		waitCycle();
		regRead = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic countPulse(input logic secondPulse, input int cycles,
		output int highCount, output int zeroCount);
		logic [3:0] sample;
		highCount = 0;
		zeroCount = 0;
		for (int i = 0; i < cycles; i++) begin
			waitCycle();
			sample = secondPulse ? levels.pulse2 : levels.pulse1;
			if (sample == 4'd9)
				highCount++;
			else if (sample == 4'd0)
				zeroCount++;
		end
	endtask

	task automatic peakPulse(input int cycles, output logic [3:0] peak);
		peak = 4'd0;
		for (int i = 0; i < cycles; i++) begin
			waitCycle();
			if (levels.pulse1 > peak)
				peak = levels.pulse1;
		end
	endtask

	task automatic compareNoise(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			waitCycle();
			checkValue("levels.noise", 32'(levels.noise), noiseModel[0] ? 32'd0 : 32'd6);
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic testLengthStatus();
		logic [7:0] status;
		writeReg(apuPkg::AddrStatus, 8'h0F);
		writeReg(5'h03, 8'h08);
		writeReg(5'h07, 8'h08);
		writeReg(5'h0F, 8'h08);
		readStatus(status);
		checkValue("statusData[3:0]", 32'(status[3:0]), 32'h0B);
		writeReg(apuPkg::AddrStatus, 8'h00);
		readStatus(status);
		checkValue("statusData[3:0]", 32'(status[3:0]), 32'h00);
	endtask

	task automatic runCountdown(input logic halt);
		logic [7:0] status;
		writeReg(apuPkg::AddrStatus, 8'h00);
		writeReg(apuPkg::AddrStatus, 8'h01);
		writeReg(5'h00, halt ? 8'h20 : 8'h00);
		// Length index 3 loads 2
		writeReg(5'h03, 8'h18);
		readStatus(status);
		checkValue("statusData[0]", 32'(status[0]), 32'd1);
		writeReg(apuPkg::AddrFrame, 8'h80);
		readStatus(status);
		checkValue("statusData[0]", 32'(status[0]), 32'd1);
		writeReg(apuPkg::AddrFrame, 8'h80);
		readStatus(status);
		checkValue("statusData[0]", 32'(status[0]), halt ? 32'd1 : 32'd0);
	endtask

	task automatic testFrameInterrupt();
		logic [7:0] status;
		logic irqSeen;
		writeReg(apuPkg::AddrFrame, 8'h40);
		writeReg(apuPkg::AddrFrame, 8'h00);
		repeat (29828) @(posedge clk);
		#DriveDelay;
		checkValue("irq", 32'(irq), 32'd0);
		waitCycle();
		checkValue("irq", 32'(irq), 32'd1);
		readStatus(status);
		checkValue("statusData[6]", 32'(status[6]), 32'd1);
		checkValue("irq", 32'(irq), 32'd0);
		checkValue("statusData[6]", 32'(statusData[6]), 32'd0);

		// Inhibited: no interrupt over a whole frame
		writeReg(apuPkg::AddrFrame, 8'h40);
		irqSeen = 1'b0;
		for (int i = 0; i < 29830; i++) begin
			waitCycle();
			irqSeen = irqSeen | irq;
		end
		checkValue("irq", 32'(irqSeen), 32'd0);
		checkValue("statusData[6]", 32'(statusData[6]), 32'd0);
	endtask

	task automatic testDutyMute();
		int highCount;
		int zeroCount;
		writeReg(apuPkg::AddrStatus, 8'h01);
		// Duty 2, halt, constant volume 9
		writeReg(5'h00, 8'hB9);
		writeReg(5'h02, 8'd20);
		writeReg(5'h03, 8'h08);
		repeat (DutyWindow) @(posedge clk);
		countPulse(1'b0, DutyWindow, highCount, zeroCount);
		checkValue("levels.pulse1 high count", highCount, DutyWindow / 2);
		checkValue("levels.pulse1 zero count", zeroCount, DutyWindow / 2);

		writeReg(5'h00, 8'h39);
		countPulse(1'b0, DutyWindow, highCount, zeroCount);
		checkValue("levels.pulse1 high count", highCount, DutyWindow / 8);
		checkValue("levels.pulse1 zero count", zeroCount, DutyWindow - DutyWindow / 8);

		writeReg(5'h02, 8'd5);
		countPulse(1'b0, DutyWindow, highCount, zeroCount);
		checkValue("levels.pulse1 zero count", zeroCount, DutyWindow);

		// Pulse 2 with duty 1, halt, constant volume 9
		writeReg(apuPkg::AddrStatus, 8'h03);
		writeReg(5'h04, 8'h79);
		writeReg(5'h06, 8'd20);
		writeReg(5'h07, 8'h08);
		countPulse(1'b1, DutyWindow, highCount, zeroCount);
		checkValue("levels.pulse2 high count", highCount, DutyWindow / 4);
		checkValue("levels.pulse2 zero count", zeroCount, DutyWindow - DutyWindow / 4);
	endtask

	task automatic runEnvelope(input logic loopMode);
		logic [3:0] expectedLevel;
		logic [3:0] peak;
		expectedLevel = 4'd0;
		writeReg(apuPkg::AddrStatus, 8'h01);
		writeReg(apuPkg::AddrFrame, 8'h80);
		// Duty 3, decaying envelope with volume 0 as divider reload
		writeReg(5'h00, loopMode ? 8'hE0 : 8'hC0);
		writeReg(5'h02, 8'h08);
		writeReg(5'h03, 8'h08);
		for (int k = 0; k < 18; k++) begin
			writeReg(apuPkg::AddrFrame, 8'h80);
			if (k == 0)
				expectedLevel = 4'd15;
			else if (expectedLevel != 4'd0)
				expectedLevel = expectedLevel - 4'd1;
			else if (loopMode)
				expectedLevel = 4'd15;
			peakPulse(150, peak);
			checkValue("levels.pulse1 peak", 32'(peak), 32'(expectedLevel));
		end
	endtask

	task automatic testNoise();
		writeReg(apuPkg::AddrStatus, 8'h08);
		// Length halt, constant volume 6
		writeReg(5'h0C, 8'h36);
		writeReg(5'h0E, 8'h00);
		writeReg(5'h0F, 8'h08);
		compareNoise(200 * NoisePeriod0);
		writeReg(5'h0E, 8'h80);
		compareNoise(200 * NoisePeriod0);
	endtask

	initial begin
		reset = 1'b1;
		ce = 1'b1;
		regWrite = 1'b0;
		regRead = 1'b0;
		regAddr = '0;
		regData = '0;
		repeat (2) @(posedge clk);
		#DriveDelay;
		reset = 1'b0;

		testLengthStatus();
		runCountdown(1'b0);
		runCountdown(1'b1);
		testFrameInterrupt();
		testDutyMute();
		runEnvelope(1'b0);
		runEnvelope(1'b1);
		testNoise();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
src/apuPkg.sv
src/lengthCounter.sv
src/envelope.sv
src/pulseChannel.sv
src/noiseChannel.sv
src/frameSequencer.sv
src/apuTop.sv
bench/apuBench.sv

// File: run.sh
#!/usr/bin/env bash
# Build the APU testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module apuBench -f sim.f -o apuSim

./obj_dir/apuSim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
